// ==== hw/cache_pkg.sv ====
package cache_pkg;

	// Bits in one ISA word.
	localparam int word_width = 64;

	// Bits in one RAM block, moved to and from memory in one transfer.
	localparam int block_width = 128;

	// Bits that pick one word out of a block.
	localparam int word_sel_width = $clog2(block_width / word_width);

	// Bits that address a block, byte offset within the block removed.
	localparam int block_addr_width = word_width - $clog2(block_width / 8);

	typedef logic [word_width-1:0] word_t;
	typedef logic [block_width-1:0] block_t;
	typedef logic [block_addr_width-1:0] block_addr_t;
	typedef logic [word_sel_width-1:0] word_sel_t;

	// CPU word address.
	// Block address in the upper bits, word index in the lower bits.
	typedef logic [block_addr_width+word_sel_width-1:0] word_addr_t;

	// Operation requested by the CPU.
	typedef enum logic [1:0] {
		op_none,
		op_load,
		op_store,
		op_flush
	} cache_op_t;

endpackage

// ==== hw/mem_cmd_if.sv ====
`timescale 1ns/1ps

interface mem_cmd_if;
	import cache_pkg::*;

	// One-cycle command strobe.
	logic start;
	// Write the cached block back first.
	logic writeback;
	// Read a new block after any write-back.
	logic fill;
	// Address the cached block came from.
	block_addr_t wb_addr;
	// Address of the block to read.
	block_addr_t fill_addr;
	// One-cycle pulse once the last transfer is over.
	logic done;

	modport ctrl (
		output start, writeback, fill, wb_addr, fill_addr,
		input done
	);

	modport port (
		input start, writeback, fill, wb_addr, fill_addr,
		output done
	);
endinterface

// ==== hw/block_if.sv ====
`timescale 1ns/1ps

interface block_if;
	import cache_pkg::*;

	// Word path, driven by the controller.
	word_sel_t word_sel;
	logic write_word;
	word_t write_value;

	// Fill path, driven by the memory port.
	logic fill;
	block_t fill_data;

	// Contents of the cached block.
	block_t block;
	word_t read_word;

	modport ctrl (
		output word_sel, write_word, write_value
	);

	// Memory port side.
	// Needs the whole block for write-back.
	modport filler (
		output fill, fill_data,
		input block
	);

	modport store (
		input word_sel, write_word, write_value, fill, fill_data,
		output block, read_word
	);
endinterface

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
	input logic clock,
	input logic reset,
	input cache_pkg::cache_op_t op,
	input cache_pkg::word_addr_t addr,
	input cache_pkg::word_t store_value,
	output logic busy,
	mem_cmd_if.ctrl mem_cmd,
	block_if.ctrl blk
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		st_clean,
		st_dirty,
		st_xfer
	} state_t;

	state_t state;
	state_t next_state;
	logic valid;
	logic next_valid;
	block_addr_t cached_addr;
	block_addr_t next_cached_addr;

	block_addr_t op_block;
	word_sel_t op_word;
	logic hit;

	// Split the CPU address into block address and word index.
	assign op_block = addr[word_sel_width +: block_addr_width];
	assign op_word = addr[word_sel_width-1:0];

	// Hit only when a block has been loaded at all.
	assign hit = valid && (op_block == cached_addr);

	// Word path follows the CPU address directly.
	assign blk.word_sel = op_word;
	assign blk.write_value = store_value;

	// Write back from the old address, fill from the new one.
	assign mem_cmd.wb_addr = cached_addr;
	assign mem_cmd.fill_addr = op_block;

	always_comb begin
		next_state = state;
		next_valid = valid;
		next_cached_addr = cached_addr;
		busy = 1'b0;
		mem_cmd.start = 1'b0;
		mem_cmd.writeback = 1'b0;
		mem_cmd.fill = 1'b0;
		blk.write_word = 1'b0;

		case (state)
			st_clean, st_dirty: begin
				case (op)
					op_load, op_store: begin
						if (hit) begin
							// Store hit merges the word and marks the block dirty.
							if (op == op_store) begin
								blk.write_word = 1'b1;
								next_state = st_dirty;
							end
						end else begin
							// Miss.
							// A dirty block goes back to memory before the fill.
							busy = 1'b1;
							mem_cmd.start = 1'b1;
							mem_cmd.writeback = (state == st_dirty);
							mem_cmd.fill = 1'b1;
							next_state = st_xfer;
							next_valid = 1'b1;
							next_cached_addr = op_block;
						end
					end
					op_flush: begin
						// Only a dirty block needs a write-back.
						if (state == st_dirty) begin
							busy = 1'b1;
							mem_cmd.start = 1'b1;
							mem_cmd.writeback = 1'b1;
							next_state = st_xfer;
						end
					end
					default: ;
				endcase
			end
			st_xfer: begin
				// Held operation is retried once the block is clean.
				busy = 1'b1;
				if (mem_cmd.done) begin
					next_state = st_clean;
				end
			end
			default: next_state = st_clean;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_clean;
			valid <= 1'b0;
			cached_addr <= '0;
		end else begin
			state <= next_state;
			valid <= next_valid;
			cached_addr <= next_cached_addr;
		end
	end
endmodule

// ==== hw/block_store.sv ====
`timescale 1ns/1ps

module block_store (
	input logic clock,
	input logic reset,
	block_if.store blk
);
	import cache_pkg::*;

	// The one cached block.
	block_t block_q;

	// Bit offset of the selected word.
	int unsigned word_lsb;

	assign word_lsb = blk.word_sel * word_width;

	always_ff @(posedge clock) begin
		if (reset) begin
			block_q <= '0;
		end else if (blk.fill) begin
			// Fill replaces the whole block.
			block_q <= blk.fill_data;
		end else if (blk.write_word) begin
			// Store replaces only the selected word.
			block_q[word_lsb +: word_width] <= blk.write_value;
		end
	end

	// Whole block for write-back.
	assign blk.block = block_q;

	// Selected word for loads, no register in the path.
	assign blk.read_word = block_q[word_lsb +: word_width];
endmodule

// ==== hw/mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
	input logic clock,
	input logic reset,
	mem_cmd_if.port mem_cmd,
	block_if.filler blk,
	output logic mem_req,
	output logic mem_write,
	output cache_pkg::block_addr_t mem_addr,
	output cache_pkg::block_t mem_write_data,
	input logic mem_ack,
	input cache_pkg::block_t mem_read_data
);
	import cache_pkg::*;

	// Handshake phase of the current transfer.
	typedef enum logic [1:0] {
		ph_idle,
		ph_req,
		ph_release
	} phase_t;

	phase_t phase;
	logic fill_pending;
	logic done_q;
	logic fill_q;
	block_addr_t fill_addr_q;
	block_t read_data_q;

	logic launch;
	logic chain_fill;
	logic capture;

	// Command accepted while idle.
	assign launch = (phase == ph_idle) && mem_cmd.start;

	// Write-back finished and a fill follows.
	assign chain_fill = (phase == ph_release) && !mem_ack && mem_write && fill_pending;

	// Read data is valid while ack is high.
	assign capture = (phase == ph_req) && mem_ack && !mem_write;

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= ph_idle;
			mem_req <= 1'b0;
			mem_write <= 1'b0;
			fill_pending <= 1'b0;
			done_q <= 1'b0;
			fill_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			fill_q <= 1'b0;
			case (phase)
				ph_idle: begin
					if (launch) begin
						if (mem_cmd.writeback || mem_cmd.fill) begin
							mem_req <= 1'b1;
							mem_write <= mem_cmd.writeback;
							fill_pending <= mem_cmd.fill;
							phase <= ph_req;
						end else begin
							done_q <= 1'b1;
						end
					end
				end
				ph_req: begin
					// Drop req once memory acknowledges.
					if (mem_ack) begin
						mem_req <= 1'b0;
						phase <= ph_release;
					end
				end
				ph_release: begin
					// Wait for ack to fall before the next request.
					if (chain_fill) begin
						mem_req <= 1'b1;
						mem_write <= 1'b0;
						phase <= ph_req;
					end else if (!mem_ack) begin
						done_q <= 1'b1;
						fill_q <= !mem_write;
						phase <= ph_idle;
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	// Address and data stay fixed for a whole transfer.
	always_ff @(posedge clock) begin
		if (launch) begin
			fill_addr_q <= mem_cmd.fill_addr;
			mem_write_data <= blk.block;
			mem_addr <= mem_cmd.writeback ? mem_cmd.wb_addr : mem_cmd.fill_addr;
		end else if (chain_fill) begin
			mem_addr <= fill_addr_q;
		end
		if (capture) begin
			read_data_q <= mem_read_data;
		end
	end

	assign blk.fill = fill_q;
	assign blk.fill_data = read_data_q;
	assign mem_cmd.done = done_q;
endmodule

// ==== hw/ram_cache.sv ====
`timescale 1ns/1ps

module ram_cache (
	input logic clock,
	input logic reset,

	// CPU side.
	input cache_pkg::cache_op_t op,
	input cache_pkg::word_addr_t addr,
	input cache_pkg::word_t store_value,
	output logic busy,
	output cache_pkg::word_t load_value,

	// Slow memory side, four-phase req/ack.
	output logic mem_req,
	output logic mem_write,
	output cache_pkg::block_addr_t mem_addr,
	output cache_pkg::block_t mem_write_data,
	input logic mem_ack,
	input cache_pkg::block_t mem_read_data
);
	// Transfer commands from controller to memory port.
	mem_cmd_if mem_cmd_bus ();

	// Word and fill paths around the block store.
	block_if blk_bus ();

	cache_ctrl u_ctrl (
		.clock(clock),
		.reset(reset),
		.op(op),
		.addr(addr),
		.store_value(store_value),
		.busy(busy),
		.mem_cmd(mem_cmd_bus.ctrl),
		.blk(blk_bus.ctrl)
	);

	block_store u_store (
		.clock(clock),
		.reset(reset),
		.blk(blk_bus.store)
	);

	mem_port u_port (
		.clock(clock),
		.reset(reset),
		.mem_cmd(mem_cmd_bus.port),
		.blk(blk_bus.filler),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_write_data(mem_write_data),
		.mem_ack(mem_ack),
		.mem_read_data(mem_read_data)
	);

	// Load data comes straight from the block store.
	assign load_value = blk_bus.read_word;
endmodule

// ==== verif/ram_cache_tb.sv ====
`timescale 1ns/1ps

module ram_cache_tb;
	import cache_pkg::*;

	// About forty accesses, each at worst a write-back and a fill with slow acks.
	localparam int cycle_limit = 2000;

	localparam block_addr_t block_a = 60'h123;
	localparam block_addr_t block_b = 60'h456;

	logic clock = 1'b0;
	logic reset;
	cache_op_t op;
	word_addr_t addr;
	word_t store_value;
	logic busy;
	word_t load_value;
	logic mem_req;
	logic mem_write;
	block_addr_t mem_addr;
	block_t mem_write_data;
	logic mem_ack;
	block_t mem_read_data;

	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;
	int protocol_errors = 0;

	// Slow memory contents.
	block_t mem_model [block_addr_t];
	// Blocks as the CPU should see them, stores merged in.
	block_t shadow [block_addr_t];

	// Every memory transfer, in order of request.
	bit xfer_write_q[$];
	block_addr_t xfer_addr_q[$];
	block_t xfer_data_q[$];

	ram_cache uut (
		.clock(clock),
		.reset(reset),
		.op(op),
		.addr(addr),
		.store_value(store_value),
		.busy(busy),
		.load_value(load_value),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_write_data(mem_write_data),
		.mem_ack(mem_ack),
		.mem_read_data(mem_read_data)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// Untouched memory, every bit of the block address shows up twice.
	function automatic block_t fill_pattern(block_addr_t b);
		return {4'hc, b, 4'h3, ~b};
	endfunction

	function automatic block_t stored_block(block_addr_t b);
		if (mem_model.exists(b)) begin
			return mem_model[b];
		end
		return fill_pattern(b);
	endfunction

	function automatic block_t expected_block(block_addr_t b);
		if (shadow.exists(b)) begin
			return shadow[b];
		end
		return fill_pattern(b);
	endfunction

	// Block address sits above the word index.
	function automatic block_addr_t block_of(word_addr_t a);
		return a[word_sel_width +: block_addr_width];
	endfunction

	function automatic word_sel_t word_of(word_addr_t a);
		return a[word_sel_width-1:0];
	endfunction

	// Word 0 is the low half of the block.
	function automatic word_t expected_word(word_addr_t a);
		block_t b;
		b = expected_block(block_of(a));
		return b[int'(word_of(a)) * word_width +: word_width];
	endfunction

	function automatic void shadow_store(word_addr_t a, word_t v);
		block_t b;
		b = expected_block(block_of(a));
		b[int'(word_of(a)) * word_width +: word_width] = v;
		shadow[block_of(a)] = b;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_block(input string name, input block_t got, input block_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input block_addr_t got,
			input block_addr_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Counts writes and reads logged since base.
	task automatic expect_transfers(input int base, input int writes, input int reads,
			input string step);
		int w;
		int r;
		w = 0;
		r = 0;
		for (int i = base; i < xfer_write_q.size(); i++) begin
			if (xfer_write_q[i]) begin
				w++;
			end else begin
				r++;
			end
		end
		check_count++;
		if (w != writes || r != reads) begin
			error_count++;
			$display("%s: expected %0d memory writes and %0d reads, saw %0d and %0d",
				step, writes, reads, w, r);
		end
	endtask

	// Holds the operation until busy is low, then releases it.
	task automatic cpu_access(input cache_op_t o, input word_addr_t a, input word_t v,
			output word_t result, output int waits);
		@(posedge clock);
		op <= o;
		addr <= a;
		store_value <= v;
		waits = 0;
		@(negedge clock);
		while (busy) begin
			waits++;
			@(negedge clock);
		end
		result = load_value;
		@(posedge clock);
		op <= op_none;
	endtask

	task automatic load_and_check(input word_addr_t a);
		word_t got;
		int waits;
		cpu_access(op_load, a, '0, got, waits);
		check_word("load_value", got, expected_word(a));
	endtask

	task automatic store_word(input word_addr_t a, input word_t v);
		word_t got;
		int waits;
		cpu_access(op_store, a, v, got, waits);
		shadow_store(a, v);
	endtask

	task automatic flush_block(output int waits);
		word_t got;
		cpu_access(op_flush, '0, '0, got, waits);
	endtask

	task automatic reset_state();
		@(negedge clock);
		check_count++;
		if (busy !== 1'b0 || mem_req !== 1'b0) begin
			error_count++;
			$display("busy or mem_req is not low after reset");
		end
	endtask

	task automatic first_load_miss();
		int base;
		base = xfer_write_q.size();
		load_and_check({block_a, 1'b1});
		expect_transfers(base, 0, 1, "first load");
		if (xfer_addr_q.size() > base) begin
			check_addr("mem_addr", xfer_addr_q[base], block_a);
		end
	endtask

	task automatic hit_loads();
		int base;
		base = xfer_write_q.size();
		load_and_check({block_a, 1'b0});
		load_and_check({block_a, 1'b1});
		expect_transfers(base, 0, 0, "load hits");
	endtask

	task automatic store_then_load();
		int base;
		base = xfer_write_q.size();
		store_word({block_a, 1'b0}, 64'hdead_beef_0123_4567);
		load_and_check({block_a, 1'b0});
		// Other word must be untouched.
		load_and_check({block_a, 1'b1});
		expect_transfers(base, 0, 0, "store hit");
	endtask

	task automatic dirty_miss_writeback();
		int base;
		base = xfer_write_q.size();
		load_and_check({block_b, 1'b0});
		expect_transfers(base, 1, 1, "miss on dirty block");
		if (xfer_write_q.size() >= base + 2) begin
			check_count++;
			if (!xfer_write_q[base] || xfer_write_q[base + 1]) begin
				error_count++;
				$display("write-back did not come before the fill");
			end
			check_addr("mem_addr", xfer_addr_q[base], block_a);
			check_block("mem_write_data", xfer_data_q[base], expected_block(block_a));
			check_addr("mem_addr", xfer_addr_q[base + 1], block_b);
		end
		// Old block comes back from memory with the stored word.
		base = xfer_write_q.size();
		load_and_check({block_a, 1'b0});
		expect_transfers(base, 0, 1, "reload of written-back block");
	endtask

	task automatic flush_dirty();
		int base;
		int waits;
		store_word({block_a, 1'b1}, 64'h0f1e_2d3c_4b5a_6978);
		base = xfer_write_q.size();
		flush_block(waits);
		expect_transfers(base, 1, 0, "flush of dirty block");
		if (xfer_write_q.size() > base) begin
			check_addr("mem_addr", xfer_addr_q[base], block_a);
			check_block("mem_write_data", xfer_data_q[base], expected_block(block_a));
		end
		base = xfer_write_q.size();
		flush_block(waits);
		expect_transfers(base, 0, 0, "second flush");
		check_count++;
		if (waits != 0) begin
			error_count++;
			$display("second flush held busy high for %0d cycles", waits);
		end
	endtask

	// Mixed traffic over four neighbouring blocks, then everything flushed out.
	task automatic random_traffic();
		word_addr_t a;
		block_addr_t b;
		word_sel_t s;
		int unsigned pick;
		int waits;
		for (int i = 0; i < 30; i++) begin
			b = block_addr_t'(60'h120) + block_addr_t'($urandom_range(3, 0));
			s = word_sel_t'($urandom_range(1, 0));
			a = {b, s};
			pick = $urandom_range(9, 0);
			if (pick < 5) begin
				load_and_check(a);
			end else if (pick < 8) begin
				store_word(a, {$urandom(), $urandom()});
			end else begin
				flush_block(waits);
			end
		end
		flush_block(waits);
		foreach (shadow[k]) begin
			check_block("mem_model", stored_block(k), shadow[k]);
		end
	endtask

	// Slow memory, random delay before each ack edge.
	initial begin : memory_model
		int unsigned delay;
		block_t data;
		mem_ack <= 1'b0;
		mem_read_data <= '0;
		forever begin
			@(negedge clock);
			if (mem_req && !mem_ack) begin
				delay = $urandom_range(3, 0);
				repeat (delay) @(negedge clock);
				xfer_write_q.push_back(mem_write);
				xfer_addr_q.push_back(mem_addr);
				if (mem_write) begin
					mem_model[mem_addr] = mem_write_data;
					xfer_data_q.push_back(mem_write_data);
					data = '0;
				end else begin
					data = stored_block(mem_addr);
					xfer_data_q.push_back(data);
				end
				@(posedge clock);
				mem_read_data <= data;
				mem_ack <= 1'b1;
				@(negedge clock);
				while (mem_req) begin
					@(negedge clock);
				end
				delay = $urandom_range(3, 0);
				repeat (delay) @(negedge clock);
				@(posedge clock);
				mem_ack <= 1'b0;
			end
		end
	end

	// Four-phase rules, sampled away from the clock edge.
	logic prev_req = 1'b0;
	logic prev_ack = 1'b0;
	logic prev_write = 1'b0;
	block_addr_t prev_addr = '0;

	always @(negedge clock) begin
		if (!reset) begin
			if (prev_req && !mem_req && !prev_ack) begin
				protocol_errors <= protocol_errors + 1;
				$display("mem_req fell while mem_ack was low");
			end
			if (!prev_req && mem_req && prev_ack) begin
				protocol_errors <= protocol_errors + 1;
				$display("mem_req rose while mem_ack was still high");
			end
			if (prev_req && mem_req && (mem_addr !== prev_addr || mem_write !== prev_write)) begin
				protocol_errors <= protocol_errors + 1;
				$display("mem_addr or mem_write changed during a request");
			end
		end
		prev_req <= mem_req;
		prev_ack <= mem_ack;
		prev_write <= mem_write;
		prev_addr <= mem_addr;
	end

	initial begin
		wait (cycle_count >= cycle_limit);
		$display("Timeout after %0d cycles, the tests did not finish", cycle_limit);
		$display("Checks failed");
		$finish;
	end

	initial begin
		void'($urandom(78));
		reset <= 1'b1;
		op <= op_none;
		addr <= '0;
		store_value <= '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		reset_state();
		first_load_miss();
		hit_loads();
		store_then_load();
		dirty_miss_writeback();
		flush_dirty();
		random_traffic();
		@(negedge clock);
		$display("Errors: %0d in %0d checks, protocol errors: %0d",
			error_count, check_count, protocol_errors);
		if (error_count == 0 && protocol_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end
endmodule

// ==== sources.f ====
hw/cache_pkg.sv
hw/mem_cmd_if.sv
hw/block_if.sv
hw/cache_ctrl.sv
hw/block_store.sv
hw/mem_port.sv
hw/ram_cache.sv
verif/ram_cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ram_cache_tb
RTL_TOP ?= ram_cache
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
